// ==== sim.f ====
pipe_pkg.sv
fetch_queue.sv
hazard_unit.sv
pipe_ctrl.sv
pipe_regs.sv
pipe_top.sv
tb_pipe.sv

// ==== Makefile ====
VERILATOR   = verilator
TOP         = tb_pipe
FILELIST    = sim.f
OBJ_DIR     = obj_dir
BUILD_FLAGS = --binary -j 0 --timing --Mdir $(OBJ_DIR)
LINT_FLAGS  = --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_pipe.sv ====
`timescale 1ns/1ns

module tb_pipe;

    localparam int WAIT_LIMIT = 400; // cycles allowed for any single wait

    logic                      clk;
    logic                      rst_n;
    logic                      inst_valid;
    pipe_pkg::inst_t           inst;
    logic                      inst_ready;
    logic                      icache_stall;
    logic                      dcache_stall;
    logic                      retire_valid;
    pipe_pkg::inst_t           retire;
    logic                      exc_valid;
    logic [pipe_pkg::PC_W-1:0] exc_pc;

    pipe_pkg::inst_t           sent[$];
    pipe_pkg::inst_t           got[$];
    pipe_pkg::inst_t           exp_ret[$];
    logic [pipe_pkg::PC_W-1:0] got_exc[$];
    logic [pipe_pkg::PC_W-1:0] exp_exc[$];
    int                        acc_cyc[$];
    int                        got_cyc[$];
    int                        cycle;
    int                        mismatches;
    int                        timeouts;
    logic [31:0]               lcg_state;

    pipe_top u_pipe_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .icache_stall (icache_stall),
        .dcache_stall (dcache_stall),
        .retire_valid (retire_valid),
        .retire       (retire),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs settle after the rising edge, so they are read in the middle of the cycle
    always @(negedge clk) begin
        if (retire_valid) begin
            got.push_back(retire);
            got_cyc.push_back(cycle);
        end
        if (exc_valid) begin
            got_exc.push_back(exc_pc);
        end
    end

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [3:0] rand_reg();
        return 4'(lcg() % 32'd15) + 4'd1;
    endfunction

    function automatic pipe_pkg::inst_t plain_inst(
        input logic [31:0] pc,
        input logic [3:0]  dst,
        input logic [3:0]  src_a,
        input logic [3:0]  src_b
    );
        pipe_pkg::inst_t it;
        it       = '0;
        it.pc    = pc;
        it.dst   = dst;
        it.src_a = src_a;
        it.src_b = src_b;
        return it;
    endfunction

    task automatic check_inst(input string name, input pipe_pkg::inst_t exp,
                              input pipe_pkg::inst_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_pc(input string name, input logic [pipe_pkg::PC_W-1:0] exp,
                            input logic [pipe_pkg::PC_W-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic push(input pipe_pkg::inst_t it, input string name);
        int t;
        t          = 0;
        inst_valid = 1'b1;
        inst       = it;
        while (!inst_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!inst_ready) begin
            $display("%s: inst_ready never came back, an instruction could not be sent", name);
            timeouts++;
        end else begin
            @(negedge clk);
            sent.push_back(it);
            acc_cyc.push_back(cycle);
        end
        inst_valid = 1'b0;
    endtask

    task automatic clear_results();
        sent.delete();
        got.delete();
        got_exc.delete();
        acc_cyc.delete();
        got_cyc.delete();
    endtask

    // walks the sent stream, a redirect skips everything until its pc shows up
    task automatic model_expected();
        logic        skipping;
        logic [31:0] want;
        exp_ret.delete();
        exp_exc.delete();
        skipping = 1'b0;
        want     = '0;
        foreach (sent[k]) begin
            if (!skipping || sent[k].pc == want) begin
                skipping = 1'b0;
                if (sent[k].exc) begin
                    exp_exc.push_back(sent[k].pc);
                    skipping = 1'b1;
                    want     = pipe_pkg::EXC_VECTOR;
                end else begin
                    exp_ret.push_back(sent[k]);
                    if (sent[k].is_branch && sent[k].taken) begin
                        skipping = 1'b1;
                        want     = {24'h0, sent[k].target};
                    end
                end
            end
        end
    endtask

    task automatic drain_and_compare(input string name);
        int t;
        int n;
        model_expected();
        t = 0;
        while ((got.size() < exp_ret.size() || got_exc.size() < exp_exc.size())
               && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (got.size() < exp_ret.size() || got_exc.size() < exp_exc.size()) begin
            $display("%s: the pipeline stopped retiring before the stream was done", name);
            timeouts++;
        end
        idle(12); // late duplicates would show up here
        check_count({name, " retire count"}, exp_ret.size(), got.size());
        n = (got.size() < exp_ret.size()) ? got.size() : exp_ret.size();
        for (int k = 0; k < n; k++) begin
            check_inst({name, " retire"}, exp_ret[k], got[k]);
        end
        check_count({name, " exception count"}, exp_exc.size(), got_exc.size());
        n = (got_exc.size() < exp_exc.size()) ? got_exc.size() : exp_exc.size();
        for (int k = 0; k < n; k++) begin
            check_pc({name, " exc_pc"}, exp_exc[k], got_exc[k]);
        end
    endtask

    task automatic straight_line_stream();
        clear_results();
        for (int k = 0; k < 8; k++) begin
            push(plain_inst(32'(k * 4), rand_reg(), rand_reg(), rand_reg()), "straight");
        end
        drain_and_compare("straight");
        if (got_cyc.size() > 0 && acc_cyc.size() > 0) begin
            check_count("straight latency", 6, got_cyc[0] - acc_cyc[0]);
        end
    endtask

    task automatic load_use_pairs();
        pipe_pkg::inst_t it;
        logic [3:0]      r;
        clear_results();
        for (int k = 0; k < 6; k++) begin
            r          = rand_reg();
            it         = plain_inst(32'h0000_0300 + 32'(k * 8), r, 4'd0, 4'd0);
            it.is_load = 1'b1;
            push(it, "load use");
            idle(int'(lcg() % 32'd3));
            it = plain_inst(32'h0000_0304 + 32'(k * 8), rand_reg(), rand_reg(), rand_reg());
            if (lcg() % 32'd2 == 32'd0) begin
                it.src_a = r;
            end else begin
                it.src_b = r;
            end
            push(it, "load use");
            idle(int'(lcg() % 32'd3));
        end
        drain_and_compare("load use");
    endtask

    task automatic taken_branch();
        pipe_pkg::inst_t it;
        clear_results();
        for (int k = 0; k < 16; k++) begin
            it = plain_inst(32'h0000_0040 + 32'(k * 4), rand_reg(), rand_reg(), rand_reg());
            if (k == 1) begin
                it.is_branch = 1'b1; // not taken, so nothing is skipped
                it.target    = 8'h20;
            end
            if (k == 3) begin
                it.is_branch = 1'b1;
                it.taken     = 1'b1;
                it.target    = 8'h70;
            end
            push(it, "branch");
        end
        drain_and_compare("branch");
    endtask

    task automatic exception_redirect();
        pipe_pkg::inst_t it;
        clear_results();
        for (int k = 0; k < 14; k++) begin
            if (k < 10) begin
                it = plain_inst(32'h0000_0100 + 32'(k * 4), rand_reg(), rand_reg(), rand_reg());
            end else begin
                it = plain_inst(pipe_pkg::EXC_VECTOR + 32'((k - 10) * 4), rand_reg(),
                                rand_reg(), rand_reg());
            end
            it.exc = (k == 2);
            push(it, "exception");
        end
        drain_and_compare("exception");
    endtask

    task automatic random_cache_stalls();
        pipe_pkg::inst_t stream[$];
        pipe_pkg::inst_t it;
        logic [3:0]      r;
        logic [31:0]     rnd;
        logic            done;
        clear_results();
        done = 1'b0;
        r    = 4'd1;
        for (int k = 0; k < 20; k++) begin
            it         = plain_inst(32'h0000_0080 + 32'(k * 4), rand_reg(), r, rand_reg());
            it.is_load = (k % 3 == 0);
            if (k == 5) begin
                it.is_branch = 1'b1;
                it.taken     = 1'b1;
                it.target    = 8'hb8;
            end
            r = it.dst; // each one reads the result of the one before
            stream.push_back(it);
        end
        fork
            begin
                foreach (stream[k]) begin
                    push(stream[k], "random stalls");
                end
                done = 1'b1;
            end
            begin
                while (!done) begin
                    rnd          = lcg();
                    icache_stall = (rnd[1:0] == 2'b00);
                    dcache_stall = (rnd[5:4] == 2'b00);
                    @(negedge clk);
                end
                icache_stall = 1'b0;
                dcache_stall = 1'b0;
            end
        join
        drain_and_compare("random stalls");
    endtask

    task automatic full_queue_backpressure();
        clear_results();
        icache_stall = 1'b1; // issue frozen, so the queue only fills
        for (int k = 0; k < pipe_pkg::QUEUE_DEPTH; k++) begin
            push(plain_inst(32'h0000_0400 + 32'(k * 4), rand_reg(), 4'd0, 4'd0), "full queue");
        end
        check_count("full queue inst_ready", 0, int'(inst_ready));
        icache_stall = 1'b0;
        for (int k = pipe_pkg::QUEUE_DEPTH; k < 8; k++) begin
            push(plain_inst(32'h0000_0400 + 32'(k * 4), rand_reg(), 4'd0, 4'd0), "full queue");
        end
        drain_and_compare("full queue");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        cycle        = 0;
        mismatches   = 0;
        timeouts     = 0;
        lcg_state    = 32'h9530ac4d;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(2);
        straight_line_stream();
        load_use_pairs();
        taken_branch();
        exception_redirect();
        random_cache_stalls();
        full_queue_backpressure();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches + timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== pipe_top.sv ====
`timescale 1ns/1ns

module pipe_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  pipe_pkg::inst_t           inst,
    output logic                      inst_ready,
    input  logic                      icache_stall,
    input  logic                      dcache_stall,
    output logic                      retire_valid,
    output pipe_pkg::inst_t           retire,
    output logic                      exc_valid,
    output logic [pipe_pkg::PC_W-1:0] exc_pc
);
    pipe_pkg::stall_req_t      req;
    pipe_pkg::pipe_ctrl_t      ctrl;
    pipe_pkg::stage_t          head;
    pipe_pkg::stage_t          id2;
    pipe_pkg::stage_t          ex;
    logic                      fifo_stall_req;
    logic                      forward_req;
    logic                      b_ctrl_flush_req;
    logic                      exception_flush;
    logic [pipe_pkg::PC_W-1:0] branch_pc;
    logic                      redirect_valid;
    logic [pipe_pkg::PC_W-1:0] redirect_pc;

    assign req.icache_stall     = icache_stall;
    assign req.dcache_stall     = dcache_stall;
    assign req.fifo_stall_req   = fifo_stall_req;
    assign req.forward_req      = forward_req;
    assign req.b_ctrl_flush_req = b_ctrl_flush_req;
    assign req.exception_flush  = exception_flush;

    // a trap in lsu2 is older than any branch in id2
    assign redirect_valid = exception_flush | b_ctrl_flush_req;
    assign redirect_pc    = exception_flush ? pipe_pkg::EXC_VECTOR : branch_pc;

    fetch_queue u_fetch_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .ctrl           (ctrl),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .head           (head),
        .fifo_stall_req (fifo_stall_req)
    );

    hazard_unit u_hazard_unit (
        .id2              (id2),
        .ex               (ex),
        .ctrl             (ctrl),
        .forward_req      (forward_req),
        .b_ctrl_flush_req (b_ctrl_flush_req),
        .redirect_pc      (branch_pc)
    );

    pipe_ctrl u_pipe_ctrl (
        .req  (req),
        .ctrl (ctrl)
    );

    pipe_regs u_pipe_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .head            (head),
        .ctrl            (ctrl),
        .id2             (id2),
        .ex              (ex),
        .exception_flush (exception_flush),
        .exc_valid       (exc_valid),
        .exc_pc          (exc_pc),
        .retire_valid    (retire_valid),
        .retire          (retire)
    );

endmodule

// ==== pipe_regs.sv ====
`timescale 1ns/1ns

module pipe_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pipe_pkg::stage_t          head,
    input  pipe_pkg::pipe_ctrl_t      ctrl,
    output pipe_pkg::stage_t          id2,
    output pipe_pkg::stage_t          ex,
    output logic                      exception_flush,
    output logic                      exc_valid,
    output logic [pipe_pkg::PC_W-1:0] exc_pc,
    output logic                      retire_valid,
    output pipe_pkg::inst_t           retire
);
    pipe_pkg::stage_t lsu1;
    pipe_pkg::stage_t lsu2;
    pipe_pkg::stage_t wb;

    // next value of one stage register, a flush wins over a stall
    function automatic pipe_pkg::stage_t step(
        input pipe_pkg::stage_t      cur,
        input pipe_pkg::stage_t      nxt,
        input pipe_pkg::stage_ctrl_t c
    );
        pipe_pkg::stage_t res;
        res = cur;
        if (c.flush || c.exp_flush) begin
            res.valid = 1'b0;
        end else if (!c.stall) begin
            res = nxt;
        end
        return res;
    endfunction

    // the trap is taken only once lsu2 is free to move on
    assign exception_flush = lsu2.valid & lsu2.inst.exc & ~ctrl.lsu1_lsu2.stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id2  <= '0;
            ex   <= '0;
            lsu1 <= '0;
            lsu2 <= '0;
            wb   <= '0;
        end else begin
            id2  <= step(id2, head, ctrl.ii_id2);
            ex   <= step(ex, id2, ctrl.id2_ex);
            lsu1 <= step(lsu1, ex, ctrl.ex_lsu1);
            lsu2 <= step(lsu2, lsu1, ctrl.lsu1_lsu2);
            wb   <= step(wb, lsu2, ctrl.mem_wb); // the trapping instruction is dropped here
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            exc_valid    <= 1'b0;
        end else begin
            retire_valid <= wb.valid;
            exc_valid    <= exception_flush;
        end
    end

    always_ff @(posedge clk) begin
        retire <= wb.inst;
        if (exception_flush) begin
            exc_pc <= lsu2.inst.pc;
        end
    end

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ns

module pipe_ctrl (
    input  pipe_pkg::stall_req_t req,
    output pipe_pkg::pipe_ctrl_t ctrl
);
    logic cache_stall;
    logic exc_flush;

    assign cache_stall = req.icache_stall | req.dcache_stall;
    assign exc_flush   = req.exception_flush;

    assign ctrl.pc_stall    = req.fifo_stall_req;
    assign ctrl.fifo_flush  = req.b_ctrl_flush_req | exc_flush;
    assign ctrl.issue_stall = cache_stall | req.forward_req;

    assign ctrl.ii_id2.stall     = cache_stall | req.forward_req; // hold the consumer in id2
    assign ctrl.ii_id2.flush     = req.b_ctrl_flush_req;
    assign ctrl.ii_id2.exp_flush = exc_flush;

    // the bubble behind a load must not overwrite ex while the caches hold it
    assign ctrl.id2_ex.stall     = cache_stall;
    assign ctrl.id2_ex.flush     = req.forward_req & ~cache_stall;
    assign ctrl.id2_ex.exp_flush = exc_flush;

    assign ctrl.ex_lsu1.stall     = cache_stall;
    assign ctrl.ex_lsu1.flush     = 1'b0;
    assign ctrl.ex_lsu1.exp_flush = exc_flush;

    assign ctrl.lsu1_lsu2.stall     = cache_stall;
    assign ctrl.lsu1_lsu2.flush     = 1'b0;
    assign ctrl.lsu1_lsu2.exp_flush = exc_flush;

    assign ctrl.mem_wb.stall     = 1'b0;
    assign ctrl.mem_wb.flush     = cache_stall; // wb takes a bubble while lsu2 is frozen
    assign ctrl.mem_wb.exp_flush = exc_flush;

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
    input  pipe_pkg::stage_t          id2,
    input  pipe_pkg::stage_t          ex,
    input  pipe_pkg::pipe_ctrl_t      ctrl,
    output logic                      forward_req,
    output logic                      b_ctrl_flush_req,
    output logic [pipe_pkg::PC_W-1:0] redirect_pc
);
    logic [pipe_pkg::REG_W-1:0] load_dst;
    logic                       load_in_ex;
    logic                       uses_load;
    logic                       taken_in_id2;

    // a load result is only ready after lsu2, so a consumer right behind it has to wait
    assign load_dst   = ex.inst.dst;
    assign load_in_ex = ex.valid & ex.inst.is_load & (load_dst != '0);
    assign uses_load  = (id2.inst.src_a == load_dst) | (id2.inst.src_b == load_dst);

    assign forward_req = load_in_ex & id2.valid & uses_load;

    assign taken_in_id2 = id2.valid & id2.inst.is_branch & id2.inst.taken;

    // resolve only when the branch actually leaves id2 this cycle
    assign b_ctrl_flush_req = taken_in_id2 & ~ctrl.ii_id2.stall;

    assign redirect_pc = {{(pipe_pkg::PC_W - pipe_pkg::TARGET_W){1'b0}}, id2.inst.target};

endmodule

// ==== fetch_queue.sv ====
`timescale 1ns/1ns

module fetch_queue (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         inst_valid,
    input  pipe_pkg::inst_t              inst,
    output logic                         inst_ready,
    input  pipe_pkg::pipe_ctrl_t         ctrl,
    input  logic                         redirect_valid,
    input  logic [pipe_pkg::PC_W-1:0]    redirect_pc,
    output pipe_pkg::stage_t             head,
    output logic                         fifo_stall_req
);
    pipe_pkg::inst_t mem [pipe_pkg::QUEUE_DEPTH];

    logic [pipe_pkg::QUEUE_AW-1:0] rd_ptr;
    logic [pipe_pkg::QUEUE_AW-1:0] wr_ptr;
    logic [pipe_pkg::QUEUE_AW:0]   count;
    logic                          armed;
    logic [pipe_pkg::PC_W-1:0]     filter_pc;
    logic [pipe_pkg::PC_W-1:0]     want_pc;
    logic                          accept;
    logic                          filtering;
    logic                          keep;
    logic                          pop;

    assign fifo_stall_req = (count == (pipe_pkg::QUEUE_AW + 1)'(pipe_pkg::QUEUE_DEPTH));
    assign inst_ready     = ~ctrl.pc_stall;
    assign accept         = inst_valid & inst_ready;

    // a redirect in this very cycle already filters the word arriving with it
    assign filtering = armed | redirect_valid;
    assign want_pc   = redirect_valid ? redirect_pc : filter_pc;
    assign keep      = accept & (~filtering | (inst.pc == want_pc));

    assign head.valid = (count != '0);
    assign head.inst  = mem[rd_ptr];
    assign pop        = head.valid & ~ctrl.issue_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (ctrl.fifo_flush) begin
            rd_ptr <= '0;
            wr_ptr <= (pipe_pkg::QUEUE_AW)'(keep); // a matching arrival lands in slot 0
            count  <= (pipe_pkg::QUEUE_AW + 1)'(keep);
        end else begin
            if (keep) begin
                wr_ptr <= wr_ptr + (pipe_pkg::QUEUE_AW)'(1'b1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + (pipe_pkg::QUEUE_AW)'(1'b1);
            end
            count <= count + (pipe_pkg::QUEUE_AW + 1)'(keep) - (pipe_pkg::QUEUE_AW + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.fifo_flush) begin
            if (keep) begin
                mem[0] <= inst;
            end
        end else if (keep) begin
            mem[wr_ptr] <= inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (redirect_valid) begin
            armed <= ~keep; // stays armed until the redirect pc shows up
        end else if (keep) begin
            armed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            filter_pc <= redirect_pc;
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    localparam int PC_W     = 32;
    localparam int REG_W    = 4;
    localparam int TARGET_W = 8;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

    localparam logic [PC_W-1:0] EXC_VECTOR = 32'h0000_00f0; // fetch resumes here after a trap

    // one instruction as it travels down the pipe, register 0 means no operand
    typedef struct packed {
        logic [PC_W-1:0]     pc;
        logic [REG_W-1:0]    dst;
        logic [REG_W-1:0]    src_a;
        logic [REG_W-1:0]    src_b;
        logic                is_load;
        logic                is_branch;
        logic                taken;
        logic                exc;
        logic [TARGET_W-1:0] target; // upper pc bits of a branch target are zero
    } inst_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
    } stage_t;

    typedef struct packed {
        logic icache_stall;
        logic dcache_stall;
        logic fifo_stall_req;
        logic forward_req;
        logic b_ctrl_flush_req;
        logic exception_flush;
    } stall_req_t;

    typedef struct packed {
        logic stall;
        logic flush;
        logic exp_flush;
    } stage_ctrl_t;

    typedef struct packed {
        stage_ctrl_t ii_id2;
        stage_ctrl_t id2_ex;
        stage_ctrl_t ex_lsu1;
        stage_ctrl_t lsu1_lsu2;
        stage_ctrl_t mem_wb;
        logic        pc_stall;
        logic        fifo_flush;
        logic        issue_stall;
    } pipe_ctrl_t;

endpackage
